/* verilog/gemm_sched_pkg.sv */
/*
  Shared widths, dimension indices, FSM states and vector types
  for the tiled GEMM scheduler. Tile sizes above MAX_T are not
  covered by the enable masks.
*/
package gemm_sched_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int DIM_W    = 10;  // Problem dims, tile indices, tile counts
  localparam int TSZ_W    = 6;   // Tile sizes, effective sizes, k_idx
  localparam int MAX_T    = 16;  // Mask bits per side
  localparam int NUM_DIMS = 3;

  // Dimension slots in the per-dimension arrays
  localparam int DIM_M = 0;
  localparam int DIM_N = 1;
  localparam int DIM_K = 2;

  // ------------------------------------------------------------
  // Vector types
  // ------------------------------------------------------------
  typedef logic [DIM_W-1:0] dim_t;   // Dimension, tile index or count
  typedef logic [TSZ_W-1:0] tsz_t;   // Tile size, eff size or k_idx
  typedef logic [MAX_T-1:0] mask_t;  // Row or column enable mask

  // ------------------------------------------------------------
  // Scheduler states
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    ST_IDLE        = 3'd0,  // Waiting for start after reset
    ST_PREP_TILE   = 3'd1,  // New C tile, clear accumulators
    ST_WAIT_READY  = 3'd2,  // Selected bank not yet valid
    ST_LOAD_WEIGHT = 3'd3,  // Weights shifted into the array
    ST_STREAM_K    = 3'd4,  // Activations stream, MACs enabled
    ST_TILE_DONE   = 3'd5,  // One-cycle end-of-tile pulse
    ST_DONE        = 3'd6   // All tiles done, waits for start
  } sched_state_e;

endpackage

/* verilog/tile_if.sv */
/*
  Tile bundle between the loop walker, the per-dimension edge
  calculators and the phase FSM. Each calculator drives only
  its own slot of eff and last.
*/
`timescale 1ns/1ps

interface tile_if
  import gemm_sched_pkg::*;
();

  dim_t idx  [NUM_DIMS];  // Current tile index per dimension
  tsz_t eff  [NUM_DIMS];  // Effective size of the current tile
  logic last [NUM_DIMS];  // Current tile is the final one

  logic k_restart;  // Zero k tile at start of a C tile
  logic k_step;     // Advance to next k tile
  logic mn_step;    // Advance n, carry into m

  // Loop-nest counter
  modport walker (output idx, input k_restart, input k_step, input mn_step, input last);

  // Edge calculators
  modport calc (input idx, output eff, output last);

  // Phase FSM
  modport fsm (input idx, input eff, input last, output k_restart, output k_step,
               output mn_step);

endinterface

/* verilog/tile_walker.sv */
/*
  Loop-nest counter with m outer, n middle, k inner.
  Indices change on the edge after a strobe. Wrapping relies on
  the last flags from the edge calculators.
*/
`timescale 1ns/1ps

module tile_walker
  import gemm_sched_pkg::*;
(
  input  logic   clk_gated,
  input  logic   rst_n,
  tile_if.walker tif
);

  dim_t m_q;  // Row tile index
  dim_t n_q;  // Column tile index
  dim_t k_q;  // Depth tile index

  // ------------------------------------------------------------
  // k index, restarted per C tile
  // ------------------------------------------------------------
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      k_q <= '0;
    end else if (tif.k_restart) begin
      k_q <= '0;
    end else if (tif.k_step) begin
      k_q <= k_q + 1'b1;  // FSM only steps when k is not last
    end
  end

  // ------------------------------------------------------------
  // m and n indices, n inner
  // ------------------------------------------------------------
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      m_q <= '0;
      n_q <= '0;
    end else if (tif.mn_step) begin
      if (tif.last[DIM_N]) begin
        n_q <= '0;                   // Row of tiles finished
        if (tif.last[DIM_M]) begin
          m_q <= '0;                 // Whole matrix finished, back to origin
        end else begin
          m_q <= m_q + 1'b1;
        end
      end else begin
        n_q <= n_q + 1'b1;
      end
    end
  end

  // Publish indices to the calculators and the FSM
  always_comb begin
    tif.idx[DIM_M] = m_q;
    tif.idx[DIM_N] = n_q;
    tif.idx[DIM_K] = k_q;
  end

endmodule

/* verilog/dim_edge_calc.sv */
/*
  Edge handling for one dimension, purely combinational.
  Assumes dim and tsz are non-zero while busy; a zero tile size
  gives a count of zero instead of a divide fault.
*/
`timescale 1ns/1ps

module dim_edge_calc
  import gemm_sched_pkg::*;
#(
  parameter int DIM = DIM_M  // Slot in the tile bundle
) (
  tile_if.calc tif,
  input  dim_t dim,          // Problem size along this dimension
  input  tsz_t tsz           // Nominal tile size
);

  localparam int OFF_W = DIM_W + TSZ_W;

  logic [OFF_W-1:0] offset;  // idx * tsz
  logic [OFF_W-1:0] remain;  // Elements left from offset on
  logic [DIM_W:0]   dim_up;  // dim + tsz - 1, one guard bit
  dim_t             count;   // ceil(dim / tsz)
  logic [DIM_W:0]   idx_p1;  // idx + 1 without wrap

  assign offset = OFF_W'(tif.idx[DIM]) * OFF_W'(tsz);

  // Zero once past the end, which only happens on bad inputs
  assign remain = (OFF_W'(dim) > offset) ? (OFF_W'(dim) - offset) : '0;

  // Clamp to the nominal tile size, so interior tiles are full
  assign tif.eff[DIM] = (remain > OFF_W'(tsz)) ? tsz : remain[TSZ_W-1:0];

  // ------------------------------------------------------------
  // Tile count and last flag
  // ------------------------------------------------------------
  assign dim_up = (DIM_W+1)'(dim) + (DIM_W+1)'(tsz) - 1'b1;
  assign count  = (tsz == '0) ? '0 : dim_t'(dim_up / (DIM_W+1)'(tsz));
  assign idx_p1 = (DIM_W+1)'(tif.idx[DIM]) + 1'b1;

  assign tif.last[DIM] = (idx_p1 >= (DIM_W+1)'(count));

endmodule

/* verilog/k_phase_fsm.sv */
/*
  Phase FSM for the weight-stationary schedule. Every k slice
  runs a load phase and a stream phase of eff[K] cycles each.
  The only back-pressure is the bank-valid wait. Outputs decode
  the registered state and k counter without delay.
*/
`timescale 1ns/1ps

module k_phase_fsm
  import gemm_sched_pkg::*;
(
  input  logic  clk_gated,
  input  logic  rst_n,
  input  logic  start,
  input  logic  valid_a_ping,
  input  logic  valid_a_pong,
  input  logic  valid_b_ping,
  input  logic  valid_b_pong,
  tile_if.fsm   tif,
  output logic  rd_en,
  output logic  clr,
  output logic  en,
  output logic  load_weight,
  output logic  bank_sel,
  output logic  busy,
  output logic  done_tile,
  output tsz_t  k_idx,
  output mask_t row_mask,
  output mask_t col_mask
);

  sched_state_e state_q, state_d;
  tsz_t         k_cnt_q;     // Position inside the current k slice
  logic         k_end;       // Last cycle of a load or stream phase
  logic         bank_ready;  // Both operand banks valid for this k tile
  logic         in_phase;    // Load or stream active

  // ------------------------------------------------------------
  // Bank select, even k tile reads ping
  // ------------------------------------------------------------
  assign bank_sel   = tif.idx[DIM_K][0];
  assign bank_ready = bank_sel ? (valid_a_pong & valid_b_pong)
                               : (valid_a_ping & valid_b_ping);

  assign in_phase = (state_q == ST_LOAD_WEIGHT) || (state_q == ST_STREAM_K);
  assign k_end    = (k_cnt_q == tsz_t'(tif.eff[DIM_K] - 1'b1));

  // ------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE, ST_DONE: begin
        if (start) state_d = ST_PREP_TILE;
      end
      ST_PREP_TILE:  state_d = ST_WAIT_READY;
      ST_WAIT_READY: begin
        if (bank_ready) state_d = ST_LOAD_WEIGHT;  // Stall otherwise
      end
      ST_LOAD_WEIGHT: begin
        if (k_end) state_d = ST_STREAM_K;
      end
      ST_STREAM_K: begin
        if (k_end) begin
          state_d = tif.last[DIM_K] ? ST_TILE_DONE : ST_WAIT_READY;
        end
      end
      ST_TILE_DONE: begin
        // Flags still describe the tile just finished
        if (tif.last[DIM_M] && tif.last[DIM_N]) begin
          state_d = ST_DONE;
        end else begin
          state_d = ST_PREP_TILE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // ------------------------------------------------------------
  // State and k counter registers
  // ------------------------------------------------------------
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      k_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (in_phase && !k_end) begin
        k_cnt_q <= k_cnt_q + 1'b1;
      end else begin
        k_cnt_q <= '0;  // Wrap between phases, idle at zero
      end
    end
  end

  // ------------------------------------------------------------
  // Array controls and walker strobes
  // ------------------------------------------------------------
  assign load_weight = (state_q == ST_LOAD_WEIGHT);
  assign en          = (state_q == ST_STREAM_K);
  assign rd_en       = in_phase;          // Weights then activations
  assign clr         = (state_q == ST_PREP_TILE);
  assign done_tile   = (state_q == ST_TILE_DONE);
  assign busy        = (state_q != ST_IDLE) && (state_q != ST_DONE);
  assign k_idx       = k_cnt_q;

  assign tif.k_restart = (state_q == ST_PREP_TILE);
  assign tif.k_step    = en && k_end && !tif.last[DIM_K];
  assign tif.mn_step   = done_tile;

  // Edge masks, low eff bits set
  always_comb begin
    for (int i = 0; i < MAX_T; i++) begin
      row_mask[i] = (i < int'(tif.eff[DIM_M]));
      col_mask[i] = (i < int'(tif.eff[DIM_N]));
    end
  end

endmodule

/* verilog/gemm_tile_sched.sv */
/*
  Tiled weight-stationary GEMM scheduler, top level.
  Dimensions and tile sizes must be non-zero and held stable
  while busy. Tile sizes above 16 exceed the mask width.
*/
`timescale 1ns/1ps

module gemm_tile_sched
  import gemm_sched_pkg::*;
(
  input  logic  clk_gated,
  input  logic  rst_n,
  input  logic  start,
  input  dim_t  m_dim,
  input  dim_t  n_dim,
  input  dim_t  k_dim,
  input  tsz_t  tm,
  input  tsz_t  tn,
  input  tsz_t  tk,
  input  logic  valid_a_ping,
  input  logic  valid_a_pong,
  input  logic  valid_b_ping,
  input  logic  valid_b_pong,
  output logic  rd_en,
  output logic  clr,
  output logic  en,
  output logic  load_weight,
  output logic  bank_sel,
  output logic  busy,
  output logic  done_tile,
  output tsz_t  k_idx,
  output mask_t row_mask,
  output mask_t col_mask,
  output dim_t  m_tile,
  output dim_t  n_tile,
  output dim_t  k_tile
);

  tile_if tif ();

  dim_t dims [NUM_DIMS];  // Problem size per dimension
  tsz_t tszs [NUM_DIMS];  // Tile size per dimension

  assign dims[DIM_M] = m_dim;
  assign dims[DIM_N] = n_dim;
  assign dims[DIM_K] = k_dim;
  assign tszs[DIM_M] = tm;
  assign tszs[DIM_N] = tn;
  assign tszs[DIM_K] = tk;

  // ------------------------------------------------------------
  // Loop nest and edge handling
  // ------------------------------------------------------------
  tile_walker i_walker (
    .clk_gated (clk_gated),
    .rst_n     (rst_n),
    .tif       (tif.walker)
  );

  for (genvar d = 0; d < NUM_DIMS; d++) begin : g_dim
    dim_edge_calc #(.DIM(d)) i_calc (
      .tif (tif.calc),
      .dim (dims[d]),
      .tsz (tszs[d])
    );
  end

  // ------------------------------------------------------------
  // Phase control
  // ------------------------------------------------------------
  k_phase_fsm i_fsm (
    .clk_gated    (clk_gated),
    .rst_n        (rst_n),
    .start        (start),
    .valid_a_ping (valid_a_ping),
    .valid_a_pong (valid_a_pong),
    .valid_b_ping (valid_b_ping),
    .valid_b_pong (valid_b_pong),
    .tif          (tif.fsm),
    .rd_en        (rd_en),
    .clr          (clr),
    .en           (en),
    .load_weight  (load_weight),
    .bank_sel     (bank_sel),
    .busy         (busy),
    .done_tile    (done_tile),
    .k_idx        (k_idx),
    .row_mask     (row_mask),
    .col_mask     (col_mask)
  );

  // Tile coordinates straight from the walker
  assign m_tile = tif.idx[DIM_M];
  assign n_tile = tif.idx[DIM_N];
  assign k_tile = tif.idx[DIM_K];

endmodule

/* verif/gemm_sched_assert.sv */
/*
  Protocol rules on the scheduler top level, bound into each
  instance. Rules are checked only while rst_n is high.
*/
`timescale 1ns/1ps

module gemm_sched_assert (
  input logic clk_gated,
  input logic rst_n,
  input logic load_weight,
  input logic en,
  input logic rd_en,
  input logic clr,
  input logic busy,
  input logic done_tile
);

  // ------------------------------------------------------------
  // Phase and control rules
  // ------------------------------------------------------------
  a_phase_excl: assert property (@(posedge clk_gated) disable iff (!rst_n)
    !(load_weight && en))  // Load and stream never overlap
    else $error("load_weight and en high in the same cycle");

  a_clr_busy: assert property (@(posedge clk_gated) disable iff (!rst_n)
    clr |-> busy)
    else $error("clr raised outside a busy schedule");

  // End-of-tile strobe lasts exactly one cycle
  a_done_pulse: assert property (@(posedge clk_gated) disable iff (!rst_n)
    done_tile |=> !done_tile)
    else $error("done_tile held for more than one cycle");

  a_rd_en: assert property (@(posedge clk_gated) disable iff (!rst_n)
    rd_en == (load_weight || en))  // Buffers read in both phases
    else $error("rd_en differs from load_weight or en");

endmodule

/* verif/tb_gemm_tile_sched.sv */
/*
  Testbench for the GEMM tile scheduler. Shapes run back to back,
  each started from idle or done, with bank flags held high or
  randomized. Tile sizes must stay at or below 16.
*/
`timescale 1ns/1ps

module tb_gemm_tile_sched
  import gemm_sched_pkg::*;
();

  localparam int NUM_RUNS = 4;

  typedef struct {
    dim_t m;
    dim_t n;
    dim_t k;
    tsz_t eff_m;
    tsz_t eff_n;
    tsz_t eff_k;
  } slice_t;  // One k slice of the schedule

  // M, N, K, Tm, Tn, Tk, random bank flags
  int run_dims [NUM_RUNS][7] = '{
    '{20, 12, 10,  8,  5,  4, 0},  // Edge tiles on every dimension
    '{16, 16, 16, 16, 16, 16, 1},  // Single full tile
    '{37,  9,  7, 12,  4,  3, 1},  // One-row edge in m
    '{ 5, 30, 33,  3, 16, 16, 1}   // One-deep last k slice
  };

  logic  clk_gated = 1'b0;
  logic  rst_n, start;
  dim_t  m_dim, n_dim, k_dim;
  tsz_t  tm, tn, tk;
  logic  valid_a_ping, valid_a_pong, valid_b_ping, valid_b_pong;
  logic  rd_en, clr, en, load_weight, bank_sel, busy, done_tile;
  tsz_t  k_idx;
  mask_t row_mask, col_mask;
  dim_t  m_tile, n_tile, k_tile;

  integer seed = 32'ha487;
  logic   rand_valid;
  slice_t exp_q [$];  // Expected k slices in order
  slice_t cur;        // Slice being observed
  int     tiles_seen, tile_lw, tile_en, pos;
  int     cycles = 0;
  int     cycle_limit;
  logic   prev_lw = 1'b0, prev_en = 1'b0, prev_done = 1'b0;
  logic [3:0] prev_flags = 4'h0;  // Bank flags of the previous cycle

  always #20 clk_gated = ~clk_gated;  // 40 ns period

  gemm_tile_sched i_dut (.*);

  bind gemm_tile_sched gemm_sched_assert i_assert (.*);

  // ------------------------------------------------------------
  // Failure reporting and compares
  // ------------------------------------------------------------
  task automatic report_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_dim(input string name, input dim_t exp_v, input dim_t act_v);
    if (act_v !== exp_v)
      report_failure($sformatf("ERR %0t %s expected %0d actual %0d", $time, name, exp_v, act_v));
  endtask

  task automatic check_tsz(input string name, input tsz_t exp_v, input tsz_t act_v);
    if (act_v !== exp_v)
      report_failure($sformatf("ERR %0t %s expected %0d actual %0d", $time, name, exp_v, act_v));
  endtask

  task automatic check_mask(input string name, input mask_t exp_v, input mask_t act_v);
    if (act_v !== exp_v)
      report_failure($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp_v, act_v));
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v)
      report_failure($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp_v, act_v));
  endtask

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic int ceil_div(input int a, input int b);
    return (a + b - 1) / b;
  endfunction

  function automatic int edge_size(input int dim, input int t, input int idx);
    return (dim - idx * t < t) ? dim - idx * t : t;  // Last tile may be short
  endfunction

  function automatic mask_t low_mask(input tsz_t n);
    return mask_t'((32'd1 << n) - 1);
  endfunction

  // Even k tiles read the ping banks and odd ones the pong banks
  function automatic logic bank_valid(input dim_t k, input logic [3:0] flags);
    logic a_ok;
    logic b_ok;
    a_ok = (k % 2 == 0) ? flags[3] : flags[2];
    b_ok = (k % 2 == 0) ? flags[1] : flags[0];
    return a_ok && b_ok;
  endfunction

  // Loop order m outer, n middle, k inner
  function automatic void build_expected(input int md, input int nd, input int kd,
                                         input int tmv, input int tnv, input int tkv);
    slice_t s;
    exp_q.delete();
    for (int mi = 0; mi < ceil_div(md, tmv); mi++) begin
      for (int ni = 0; ni < ceil_div(nd, tnv); ni++) begin
        for (int ki = 0; ki < ceil_div(kd, tkv); ki++) begin
          s.m     = dim_t'(mi);
          s.n     = dim_t'(ni);
          s.k     = dim_t'(ki);
          s.eff_m = tsz_t'(edge_size(md, tmv, mi));
          s.eff_n = tsz_t'(edge_size(nd, tnv, ni));
          s.eff_k = tsz_t'(edge_size(kd, tkv, ki));
          exp_q.push_back(s);
        end
      end
    end
  endfunction

  // Bank flags change on the falling edge only
  always @(negedge clk_gated) begin
    if (rand_valid) begin
      {valid_a_ping, valid_a_pong, valid_b_ping, valid_b_pong} = 4'($random(seed));
    end else begin
      {valid_a_ping, valid_a_pong, valid_b_ping, valid_b_pong} = 4'hf;
    end
  end

  // ------------------------------------------------------------
  // Monitor samples the cycle that ends at each rising edge
  // ------------------------------------------------------------
  always @(posedge clk_gated) begin
    if (rst_n) begin
      check_bit("bank_sel", k_tile[0], bank_sel);
      check_bit("rd_en", load_weight | en, rd_en);
      if (load_weight && en) report_failure("load_weight and en were high in the same cycle");
      if (clr && !busy) report_failure("clr was raised while busy was low");
      if (done_tile && prev_done) report_failure("done_tile stayed high for two cycles");
      if (clr) begin
        tile_lw = 0;
        tile_en = 0;
      end
      if (load_weight) begin
        if (!prev_lw) begin  // New k slice
          if (exp_q.size() == 0) report_failure("A weight load started after the last slice");
          cur = exp_q.pop_front();
          if (!bank_valid(cur.k, prev_flags)) begin
            report_failure("A weight load started while its bank was not valid");
          end
          check_dim("m_tile", cur.m, m_tile);
          check_dim("n_tile", cur.n, n_tile);
          check_dim("k_tile", cur.k, k_tile);
          pos = 0;
        end
        check_tsz("k_idx", tsz_t'(pos), k_idx);
        pos++;
        tile_lw++;
      end else if (prev_lw) begin
        check_tsz("load_cycles", cur.eff_k, tsz_t'(pos));
      end
      if (en) begin
        if (!prev_en) pos = 0;
        check_tsz("k_idx", tsz_t'(pos), k_idx);
        check_mask("row_mask", low_mask(cur.eff_m), row_mask);
        check_mask("col_mask", low_mask(cur.eff_n), col_mask);
        check_dim("k_tile", cur.k, k_tile);
        pos++;
        tile_en++;
      end else if (prev_en) begin
        check_tsz("stream_cycles", cur.eff_k, tsz_t'(pos));
      end
      if (done_tile) begin
        tiles_seen++;
        check_dim("m_tile", cur.m, m_tile);
        check_dim("n_tile", cur.n, n_tile);
        check_dim("load_cycles_per_tile", k_dim, dim_t'(tile_lw));  // Sum of eff_k is K
        check_dim("stream_cycles_per_tile", k_dim, dim_t'(tile_en));
      end
    end
    prev_lw    = load_weight;
    prev_en    = en;
    prev_done  = done_tile;
    prev_flags = {valid_a_ping, valid_a_pong, valid_b_ping, valid_b_pong};
  end

  // Run limit
  always @(posedge clk_gated) begin
    cycles++;
    if (cycles > cycle_limit)
      report_failure($sformatf("Timeout: schedule not finished after %0d cycles", cycle_limit));
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin
    int total;
    int wait_b;
    total = 10;  // Reset and idle check
    for (int r = 0; r < NUM_RUNS; r++) begin
      wait_b = run_dims[r][6] ? 8 : 1;  // Random flags give about 4 cycles of wait
      total += ceil_div(run_dims[r][0], run_dims[r][3]) * ceil_div(run_dims[r][1], run_dims[r][4])
               * (2 + ceil_div(run_dims[r][2], run_dims[r][5]) * wait_b + 2 * run_dims[r][2])
               + 8;
    end
    cycle_limit = 4 * total;
    rst_n      = 1'b0;
    start      = 1'b0;
    rand_valid = 1'b0;
    {m_dim, n_dim, k_dim} = '0;
    {tm, tn, tk}          = '0;
    {valid_a_ping, valid_a_pong, valid_b_ping, valid_b_pong} = 4'h0;
    repeat (4) @(negedge clk_gated);
    rst_n = 1'b1;
    repeat (3) begin  // Quiet before the first start
      @(posedge clk_gated);
      check_bit("busy", 1'b0, busy);
      check_bit("en", 1'b0, en);
      check_bit("load_weight", 1'b0, load_weight);
      check_bit("rd_en", 1'b0, rd_en);
      check_bit("clr", 1'b0, clr);
      check_bit("done_tile", 1'b0, done_tile);
    end
    for (int r = 0; r < NUM_RUNS; r++) begin
      @(negedge clk_gated);
      m_dim      = dim_t'(run_dims[r][0]);
      n_dim      = dim_t'(run_dims[r][1]);
      k_dim      = dim_t'(run_dims[r][2]);
      tm         = tsz_t'(run_dims[r][3]);
      tn         = tsz_t'(run_dims[r][4]);
      tk         = tsz_t'(run_dims[r][5]);
      rand_valid = run_dims[r][6][0];
      build_expected(run_dims[r][0], run_dims[r][1], run_dims[r][2],
                     run_dims[r][3], run_dims[r][4], run_dims[r][5]);
      tiles_seen = 0;
      start = 1'b1;
      @(negedge clk_gated);
      start = 1'b0;
      check_bit("busy", 1'b1, busy);
      while (busy) @(negedge clk_gated);
      check_dim("tile_count",
                dim_t'(ceil_div(run_dims[r][0], run_dims[r][3]) *
                       ceil_div(run_dims[r][1], run_dims[r][4])),
                dim_t'(tiles_seen));
      if (exp_q.size() != 0) report_failure("Schedule ended with k slices still expected");
    end
    repeat (2) @(negedge clk_gated);
    check_bit("busy", 1'b0, busy);  // Stays in done
    $display("TEST OK");
    $finish;
  end

endmodule

/* compile.f */
verilog/gemm_sched_pkg.sv
verilog/tile_if.sv
verilog/tile_walker.sv
verilog/dim_edge_calc.sv
verilog/k_phase_fsm.sv
verilog/gemm_tile_sched.sv
verif/gemm_sched_assert.sv
verif/tb_gemm_tile_sched.sv
